/* all.f */
hw/dma_pkg.sv
hw/dma_ifs.sv
hw/dma_regs.sv
hw/wr_buffer.sv
hw/axi_burst_writer.sv
hw/dma_wr_top.sv
bench/dma_wr_asserts.sv
bench/dma_wr_checker.sv
bench/tb_dma_wr.sv

/* bench/dma_wr_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module dma_wr_asserts #(
   parameter int DATA_W = 32
) (
   input wire logic              clk_i,
   input wire logic              rst_i,
   input wire logic              awvalid_i,
   input wire logic              awready_i,
   input wire logic              wvalid_i,
   input wire logic              wready_i,
   input wire logic              wlast_i,
   input wire logic [DATA_W-1:0] wdata_i,
   input wire logic              start_i,
   input wire logic              busy_i
);

   int fail_cnt = 0;

   // Address request stays up until accepted
   aw_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      awvalid_i && !awready_i |=> awvalid_i)
      else begin
         fail_cnt++;
         $error("awvalid dropped before awready");
      end

   // Data beat and its payload are frozen while stalled
   w_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i))
      else begin
         fail_cnt++;
         $error("wvalid or wdata changed before wready");
      end

   // Last flag stays with its stalled beat
   w_last_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      wvalid_i && !wready_i |=> $stable(wlast_i))
      else begin
         fail_cnt++;
         $error("wlast changed before wready");
      end

   // Engine only becomes busy from an accepted start
   busy_from_start: assert property (@(posedge clk_i) disable iff (rst_i)
      $rose(busy_i) |-> $past(start_i))
      else begin
         fail_cnt++;
         $error("busy rose without a start strobe");
      end

endmodule

`default_nettype wire

/* bench/dma_wr_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module dma_wr_checker #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32,
   parameter int BUF_AW = 6
) (
   input  wire logic                             clk_i,
   input  wire logic                             rst_i,
   input  wire logic                             reg_we_i,
   input  wire logic [dma_pkg::REG_AW-1:0]       reg_addr_i,
   input  wire logic [31:0]                      reg_wdata_i,
   input  wire logic [31:0]                      reg_rdata_i,
   input  wire logic                             buf_we_i,
   input  wire logic [BUF_AW-1:0]                buf_addr_i,
   input  wire logic [DATA_W-1:0]                buf_wdata_i,
   input  wire logic                             done_i,
   input  wire logic [ADDR_W-1:0]                awaddr_i,
   input  wire logic [dma_pkg::AXI_LEN_W-1:0]    awlen_i,
   input  wire logic [2:0]                       awsize_i,
   input  wire logic [1:0]                       awburst_i,
   input  wire logic                             awvalid_i,
   input  wire logic                             awready_i,
   input  wire logic [DATA_W-1:0]                wdata_i,
   input  wire logic [DATA_W/8-1:0]              wstrb_i,
   input  wire logic                             wlast_i,
   input  wire logic                             wvalid_i,
   input  wire logic                             wready_i,
   input  wire logic [dma_pkg::AXI_RESP_W-1:0]   bresp_i,
   input  wire logic                             bvalid_i,
   input  wire logic                             bready_i,
   output int                                    err_cnt_o,
   output int                                    check_cnt_o
);

   // Buffer contents and host settings as seen on the host ports
   logic [DATA_W-1:0]             buf_model [1 << BUF_AW];
   logic [ADDR_W-1:0]             addr_reg;
   logic [dma_pkg::AXI_LEN_W-1:0] len_reg;
   logic [BUF_AW-1:0]             start_reg;

   // Settings of the burst in flight
   logic [ADDR_W-1:0]             exp_addr;
   logic [dma_pkg::AXI_LEN_W-1:0] exp_len;
   logic [BUF_AW-1:0]             exp_start;
   logic                          exp_err;
   logic [31:0]                   exp_status;

   logic busy_model;
   logic aw_seen;
   logic b_hs_d;
   logic status_due;
   int   beat;
   int   done_total;
   int   errors = 0;
   int   checks = 0;

   assign err_cnt_o   = errors;
   assign check_cnt_o = checks;

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("Error at %0t: %s", $time, what);
   endtask

   always @(posedge clk_i) begin
      if (rst_i) begin
         compare_value("m_axi_awvalid_o", awvalid_i, 0);
         compare_value("m_axi_wvalid_o", wvalid_i, 0);
         compare_value("m_axi_bready_o", bready_i, 0);
         compare_value("done_o", done_i, 0);
         if (reg_addr_i == dma_pkg::REG_STATUS) begin
            compare_value("status in reset", reg_rdata_i, 0);
         end
         addr_reg   = '0;
         len_reg    = '0;
         start_reg  = '0;
         exp_err    = 1'b0;
         busy_model = 1'b0;
         aw_seen    = 1'b0;
         b_hs_d     = 1'b0;
         status_due = 1'b0;
         beat       = 0;
         done_total = 0;
      end else begin
         // Status is read two cycles after the response handshake
         if (status_due) begin
            status_due = 1'b0;
            if (!reg_we_i && reg_addr_i == dma_pkg::REG_STATUS) begin
               exp_status = '0;
               exp_status[dma_pkg::STATUS_ERR_BIT] = exp_err;
               exp_status[31:dma_pkg::STATUS_CNT_LSB] = 24'(done_total);
               compare_value("status after done", reg_rdata_i, exp_status);
            end else begin
               report_failure("status register was not selected after a transfer");
            end
         end

         compare_value("done_o", done_i, b_hs_d);
         if (b_hs_d) begin
            status_due = 1'b1;
         end

         if (buf_we_i) begin
            buf_model[buf_addr_i] = buf_wdata_i;
         end

         if (reg_we_i) begin
            case (reg_addr_i)
               dma_pkg::REG_AXI_ADDR:  addr_reg  = ADDR_W'(reg_wdata_i);
               dma_pkg::REG_LEN:       len_reg   = reg_wdata_i[dma_pkg::AXI_LEN_W-1:0];
               dma_pkg::REG_BUF_START: start_reg = reg_wdata_i[BUF_AW-1:0];
               dma_pkg::REG_CTRL: begin
                  // Start is taken only while idle
                  if (reg_wdata_i[0] && !busy_model) begin
                     busy_model = 1'b1;
                     aw_seen    = 1'b0;
                     beat       = 0;
                     exp_addr   = addr_reg;
                     exp_len    = len_reg;
                     exp_start  = start_reg;
                  end
               end
               default: ;
            endcase
         end

         if (awvalid_i && awready_i) begin
            if (!busy_model || aw_seen) begin
               report_failure("address handshake without a started transfer");
            end else begin
               aw_seen = 1'b1;
               compare_value("m_axi_awaddr_o", awaddr_i, exp_addr);
               compare_value("m_axi_awlen_o", awlen_i, exp_len);
               compare_value("m_axi_awburst_o", awburst_i, 2'b01);
               // Size code gives the beat width in bytes as a power of two
               compare_value("m_axi_awsize_o bytes", 32'd1 << awsize_i, DATA_W / 8);
            end
         end

         if (wvalid_i && wready_i) begin
            if (!busy_model || beat > exp_len) begin
               report_failure("write beat outside a burst");
            end else begin
               compare_value("m_axi_wdata_o", wdata_i,
                             buf_model[BUF_AW'(exp_start + beat)]);
               compare_value("m_axi_wlast_o", wlast_i, beat == exp_len);
               compare_value("m_axi_wstrb_o", wstrb_i, {(DATA_W / 8){1'b1}});
               beat++;
            end
         end

         if (bvalid_i && bready_i) begin
            if (!busy_model) begin
               report_failure("write response without a started transfer");
            end else begin
               if (!aw_seen) begin
                  report_failure("write response before the address handshake");
               end
               compare_value("beat count", beat, exp_len + 1);
               exp_err    = (bresp_i != dma_pkg::RESP_OKAY);
               busy_model = 1'b0;
               done_total++;
            end
         end
         b_hs_d = bvalid_i && bready_i;
      end
   end

endmodule

`default_nettype wire

/* bench/tb_dma_wr.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_dma_wr;

   localparam int ADDR_W       = 32;
   localparam int DATA_W       = 32;
   localparam int BUF_AW       = 6;
   localparam int N_XFERS      = 30;
   localparam int DONE_TIMEOUT = 2000;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   logic                          clk = 1'b0;
   logic                          rst;
   logic                          reg_we;
   logic [dma_pkg::REG_AW-1:0]    reg_addr;
   logic [31:0]                   reg_wdata;
   logic [31:0]                   reg_rdata;
   logic                          buf_we;
   logic [BUF_AW-1:0]             buf_addr;
   logic [DATA_W-1:0]             buf_wdata;
   logic                          done;

   logic [ADDR_W-1:0]             m_axi_awaddr;
   logic [dma_pkg::AXI_LEN_W-1:0] m_axi_awlen;
   logic [2:0]                    m_axi_awsize;
   logic [1:0]                    m_axi_awburst;
   logic                          m_axi_awvalid;
   logic                          m_axi_awready = 1'b0;
   logic [DATA_W-1:0]             m_axi_wdata;
   logic [DATA_W/8-1:0]           m_axi_wstrb;
   logic                          m_axi_wlast;
   logic                          m_axi_wvalid;
   logic                          m_axi_wready = 1'b0;
   logic [1:0]                    m_axi_bresp = 2'b00;
   logic                          m_axi_bvalid = 1'b0;
   logic                          m_axi_bready;

   // AXI slave responder state
   logic                          wlast_hs;
   logic                          resp_hs;
   logic                          b_owed = 1'b0;
   int                            b_delay = 0;

   logic                          hung;
   logic                          len_preset;
   logic [dma_pkg::AXI_LEN_W-1:0] next_len;
   int                            chk_errors;
   int                            chk_checks;
   int                            err_total;

   always #4 clk = ~clk;

   dma_wr_top #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W),
      .BUF_AW (BUF_AW)
   ) u_dut (
      .clk_i           (clk),
      .rst_i           (rst),
      .reg_we_i        (reg_we),
      .reg_addr_i      (reg_addr),
      .reg_wdata_i     (reg_wdata),
      .reg_rdata_o     (reg_rdata),
      .buf_we_i        (buf_we),
      .buf_addr_i      (buf_addr),
      .buf_wdata_i     (buf_wdata),
      .done_o          (done),
      .m_axi_awaddr_o  (m_axi_awaddr),
      .m_axi_awlen_o   (m_axi_awlen),
      .m_axi_awsize_o  (m_axi_awsize),
      .m_axi_awburst_o (m_axi_awburst),
      .m_axi_awvalid_o (m_axi_awvalid),
      .m_axi_awready_i (m_axi_awready),
      .m_axi_wdata_o   (m_axi_wdata),
      .m_axi_wstrb_o   (m_axi_wstrb),
      .m_axi_wlast_o   (m_axi_wlast),
      .m_axi_wvalid_o  (m_axi_wvalid),
      .m_axi_wready_i  (m_axi_wready),
      .m_axi_bresp_i   (m_axi_bresp),
      .m_axi_bvalid_i  (m_axi_bvalid),
      .m_axi_bready_o  (m_axi_bready)
   );

   dma_wr_checker #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W),
      .BUF_AW (BUF_AW)
   ) u_chk (
      .clk_i       (clk),
      .rst_i       (rst),
      .reg_we_i    (reg_we),
      .reg_addr_i  (reg_addr),
      .reg_wdata_i (reg_wdata),
      .reg_rdata_i (reg_rdata),
      .buf_we_i    (buf_we),
      .buf_addr_i  (buf_addr),
      .buf_wdata_i (buf_wdata),
      .done_i      (done),
      .awaddr_i    (m_axi_awaddr),
      .awlen_i     (m_axi_awlen),
      .awsize_i    (m_axi_awsize),
      .awburst_i   (m_axi_awburst),
      .awvalid_i   (m_axi_awvalid),
      .awready_i   (m_axi_awready),
      .wdata_i     (m_axi_wdata),
      .wstrb_i     (m_axi_wstrb),
      .wlast_i     (m_axi_wlast),
      .wvalid_i    (m_axi_wvalid),
      .wready_i    (m_axi_wready),
      .bresp_i     (m_axi_bresp),
      .bvalid_i    (m_axi_bvalid),
      .bready_i    (m_axi_bready),
      .err_cnt_o   (chk_errors),
      .check_cnt_o (chk_checks)
   );

   bind axi_burst_writer dma_wr_asserts #(.DATA_W(DATA_W)) u_asserts (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .awvalid_i (m_axi_awvalid_o),
      .awready_i (m_axi_awready_i),
      .wvalid_i  (m_axi_wvalid_o),
      .wready_i  (m_axi_wready_i),
      .wlast_i   (m_axi_wlast_o),
      .wdata_i   (m_axi_wdata_o),
      .start_i   (cmd.start),
      .busy_i    (busy_q)
   );

   // Random ready lines, delayed response, SLVERR on about one burst in four
   always @(posedge clk) begin
      wlast_hs = m_axi_wvalid && m_axi_wready && m_axi_wlast;
      resp_hs  = m_axi_bvalid && m_axi_bready;
      #1;
      if (rst) begin
         m_axi_awready = 1'b0;
         m_axi_wready  = 1'b0;
         m_axi_bvalid  = 1'b0;
         m_axi_bresp   = dma_pkg::RESP_OKAY;
         b_owed        = 1'b0;
      end else begin
         m_axi_awready = ($urandom % 4) != 0;
         m_axi_wready  = ($urandom % 3) != 0;
         if (resp_hs) begin
            m_axi_bvalid = 1'b0;
         end
         if (wlast_hs) begin
            b_owed  = 1'b1;
            b_delay = $urandom % 6;
         end
         if (b_owed && !m_axi_bvalid) begin
            if (b_delay == 0) begin
               m_axi_bvalid = 1'b1;
               m_axi_bresp  = (($urandom % 4) == 0) ? RESP_SLVERR : dma_pkg::RESP_OKAY;
               b_owed       = 1'b0;
            end else begin
               b_delay--;
            end
         end
      end
   end

   task automatic idle(input int cycles);
      repeat (cycles) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic write_reg(input logic [dma_pkg::REG_AW-1:0] addr, input logic [31:0] data);
      reg_we    = 1'b1;
      reg_addr  = addr;
      reg_wdata = data;
      idle(1);
      reg_we    = 1'b0;
      reg_addr  = dma_pkg::REG_STATUS;
   endtask

   task automatic fill_words(input logic [BUF_AW-1:0] first, input int count);
      logic [BUF_AW-1:0] idx;
      idx = first;
      for (int k = 0; k < count; k++) begin
         buf_we    = 1'b1;
         buf_addr  = idx;
         buf_wdata = $urandom;
         idle(1);
         idx = idx + 1'b1;
      end
      buf_we = 1'b0;
   endtask

   task automatic wait_done();
      int cycles;
      cycles = 0;
      while (!done && cycles < DONE_TIMEOUT) begin
         idle(1);
         cycles++;
      end
      if (!done) begin
         hung = 1'b1;
         $display("Timeout: no done strobe within %0d cycles", DONE_TIMEOUT);
      end
   endtask

   task automatic run_transfer(input int idx);
      logic [ADDR_W-1:0]             addr;
      logic [dma_pkg::AXI_LEN_W-1:0] len;
      logic [BUF_AW-1:0]             first;
      logic                          poke;
      // 64-byte aligned address keeps every burst inside one 4 KB page
      addr  = $urandom & 32'hFFFF_FFC0;
      len   = len_preset ? next_len : 8'($urandom % 16);
      first = BUF_AW'($urandom);
      poke  = (idx % 3) == 1;
      fill_words(first, len + 1);
      write_reg(dma_pkg::REG_AXI_ADDR, addr);
      if (!len_preset) begin
         write_reg(dma_pkg::REG_LEN, 32'(len));
      end
      write_reg(dma_pkg::REG_BUF_START, 32'(first));
      write_reg(dma_pkg::REG_CTRL, 32'h1);
      len_preset = 1'b0;
      if (poke) begin
         // Start while busy, then a length meant for the next burst
         idle(1);
         write_reg(dma_pkg::REG_CTRL, 32'h1);
         next_len = 8'($urandom % 16);
         write_reg(dma_pkg::REG_LEN, 32'(next_len));
         len_preset = 1'b1;
      end
      wait_done();
      idle(2);
      $display("Test transfer %0d: addr %h, %0d beats from index %0d, %s, %0d errors so far",
               idx, addr, len + 1, first, poke ? "busy writes" : "plain", chk_errors);
   endtask

   initial begin
      void'($urandom(32'h9434));
      hung       = 1'b0;
      len_preset = 1'b0;
      next_len   = '0;
      rst        = 1'b1;
      reg_we     = 1'b0;
      reg_addr   = dma_pkg::REG_STATUS;
      reg_wdata  = '0;
      buf_we     = 1'b0;
      buf_addr   = '0;
      buf_wdata  = '0;
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;
      $display("Test reset: outputs and status checked, %0d errors so far", chk_errors);
      idle(2);
      for (int i = 0; i < N_XFERS && !hung; i++) begin
         run_transfer(i);
      end
      err_total = chk_errors + u_dut.u_writer.u_asserts.fail_cnt;
      $display("Summary: %0d checks, %0d checker errors, %0d assertion failures",
               chk_checks, chk_errors, u_dut.u_writer.u_asserts.fail_cnt);
      if (hung || err_total != 0) begin
         $display("Done: errors found");
      end else begin
         $display("Done: no errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* hw/axi_burst_writer.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_burst_writer #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32,
   parameter int BUF_AW = 6
) (
   input  wire logic                             clk_i,
   input  wire logic                             rst_i,
   dma_cmd_if.engine                             cmd,
   buf_rd_if.master                              rd,

   // AXI write address
   output logic [ADDR_W-1:0]                     m_axi_awaddr_o,
   output logic [dma_pkg::AXI_LEN_W-1:0]         m_axi_awlen_o,
   output logic [dma_pkg::AXI_SIZE_W-1:0]        m_axi_awsize_o,
   output logic [dma_pkg::AXI_BURST_W-1:0]       m_axi_awburst_o,
   output logic                                  m_axi_awvalid_o,
   input  wire logic                             m_axi_awready_i,

   // AXI write data
   output logic [DATA_W-1:0]                     m_axi_wdata_o,
   output logic [DATA_W/8-1:0]                   m_axi_wstrb_o,
   output logic                                  m_axi_wlast_o,
   output logic                                  m_axi_wvalid_o,
   input  wire logic                             m_axi_wready_i,

   // AXI write response
   input  wire logic [dma_pkg::AXI_RESP_W-1:0]   m_axi_bresp_i,
   input  wire logic                             m_axi_bvalid_i,
   output logic                                  m_axi_bready_o
);

   localparam logic [dma_pkg::AXI_SIZE_W-1:0] AW_SIZE =
      dma_pkg::AXI_SIZE_W'($clog2(DATA_W / 8));

   typedef enum logic [1:0] {
      ST_ADDR = 2'd0,
      ST_DATA = 2'd1,
      ST_RESP = 2'd2
   } state_t;

   state_t                        state_q;
   logic                          busy_q;
   logic                          awvalid_q;
   logic                          done_q;
   logic                          error_q;

   // Transfer settings sampled at start
   logic [ADDR_W-1:0]             addr_q;
   logic [dma_pkg::AXI_LEN_W-1:0] len_q;

   logic [dma_pkg::AXI_LEN_W-1:0] beat_cnt_q;
   logic [BUF_AW-1:0]             rd_ptr_q;
   logic                          rd_pend_q;
   logic [DATA_W-1:0]             hold_q;
   logic                          hold_valid_q;

   logic                          start_ok;
   logic                          aw_hs;
   logic                          w_hs;
   logic                          b_hs;
   logic                          last_beat;
   logic                          fetch;

   assign start_ok  = cmd.start && !busy_q;
   assign aw_hs     = awvalid_q && m_axi_awready_i;
   assign w_hs      = m_axi_wvalid_o && m_axi_wready_i;
   assign b_hs      = m_axi_bready_o && m_axi_bvalid_i;
   assign last_beat = (beat_cnt_q == len_q);

   // Next word is fetched only after the held one has been sent
   assign fetch = busy_q && (state_q != ST_RESP) && !hold_valid_q && !rd_pend_q;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q    <= ST_ADDR;
         busy_q     <= 1'b0;
         awvalid_q  <= 1'b0;
         done_q     <= 1'b0;
         error_q    <= 1'b0;
         beat_cnt_q <= '0;
      end else begin
         done_q <= 1'b0;
         case (state_q)
            ST_ADDR: begin
               if (start_ok) begin
                  busy_q     <= 1'b1;
                  awvalid_q  <= 1'b1;
                  error_q    <= 1'b0;
                  beat_cnt_q <= '0;
               end else if (aw_hs) begin
                  awvalid_q <= 1'b0;
                  state_q   <= ST_DATA;
               end
            end
            ST_DATA: begin
               if (w_hs) begin
                  beat_cnt_q <= beat_cnt_q + 1'b1;
                  if (last_beat) begin
                     state_q <= ST_RESP;
                  end
               end
            end
            ST_RESP: begin
               if (b_hs) begin
                  error_q <= (m_axi_bresp_i != dma_pkg::RESP_OKAY);
                  done_q  <= 1'b1;
                  busy_q  <= 1'b0;
                  state_q <= ST_ADDR;
               end
            end
            default: state_q <= ST_ADDR;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (start_ok) begin
         addr_q <= cmd.axi_addr;
         len_q  <= cmd.len;
      end
   end

   // Buffer read pointer and pending request
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         rd_ptr_q  <= '0;
         rd_pend_q <= 1'b0;
      end else begin
         if (start_ok) begin
            rd_ptr_q <= cmd.buf_start;
         end else if (fetch) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         rd_pend_q <= fetch;
      end
   end

   // Held word, freed by the W handshake
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         hold_valid_q <= 1'b0;
      end else if (rd.ready) begin
         hold_valid_q <= 1'b1;
      end else if (w_hs) begin
         hold_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd.ready) begin
         hold_q <= rd.rdata;
      end
   end

   assign rd.valid = fetch;
   assign rd.addr  = rd_ptr_q;

   assign m_axi_awaddr_o  = addr_q;
   assign m_axi_awlen_o   = len_q;
   assign m_axi_awsize_o  = AW_SIZE;
   assign m_axi_awburst_o = dma_pkg::BURST_INCR;
   assign m_axi_awvalid_o = awvalid_q;

   // Full-width beats only
   assign m_axi_wdata_o  = hold_q;
   assign m_axi_wstrb_o  = '1;
   assign m_axi_wvalid_o = (state_q == ST_DATA) && hold_valid_q;
   assign m_axi_wlast_o  = m_axi_wvalid_o && last_beat;

   assign m_axi_bready_o = (state_q == ST_RESP);

   assign cmd.busy  = busy_q;
   assign cmd.done  = done_q;
   assign cmd.error = error_q;

endmodule

`default_nettype wire

/* hw/dma_ifs.sv */
`timescale 1ns/100ps
`default_nettype none

// Command and status link between register block and write engine
interface dma_cmd_if #(
   parameter int ADDR_W = 32,
   parameter int BUF_AW = 6
);
   logic                           start;
   logic [ADDR_W-1:0]              axi_addr;
   logic [dma_pkg::AXI_LEN_W-1:0]  len;
   logic [BUF_AW-1:0]              buf_start;
   logic                           busy;
   logic                           done;
   logic                           error;

   modport regs (output start, axi_addr, len, buf_start,
                 input  busy, done, error);

   modport engine (input  start, axi_addr, len, buf_start,
                   output busy, done, error);
endinterface

// Buffer read port, answered one cycle after each request
interface buf_rd_if #(
   parameter int DATA_W = 32,
   parameter int BUF_AW = 6
);
   logic              valid;
   logic [BUF_AW-1:0] addr;
   logic [DATA_W-1:0] rdata;
   logic              ready;

   modport master (output valid, addr,
                   input  rdata, ready);

   modport memory (input  valid, addr,
                   output rdata, ready);
endinterface

`default_nettype wire

/* hw/dma_pkg.sv */
`default_nettype none

package dma_pkg;

   // AXI field widths
   localparam int AXI_LEN_W   = 8;
   localparam int AXI_SIZE_W  = 3;
   localparam int AXI_BURST_W = 2;
   localparam int AXI_RESP_W  = 2;

   // Burst type and response codes
   localparam logic [AXI_BURST_W-1:0] BURST_INCR = 2'b01;
   localparam logic [AXI_RESP_W-1:0]  RESP_OKAY  = 2'b00;

   // Host register map
   localparam int REG_AW = 3;

   localparam logic [REG_AW-1:0] REG_CTRL      = 3'd0;
   localparam logic [REG_AW-1:0] REG_AXI_ADDR  = 3'd1;
   localparam logic [REG_AW-1:0] REG_LEN       = 3'd2;
   localparam logic [REG_AW-1:0] REG_BUF_START = 3'd3;
   localparam logic [REG_AW-1:0] REG_STATUS    = 3'd4;

   // Status word layout, completion count fills the upper bits
   localparam int STATUS_BUSY_BIT = 0;
   localparam int STATUS_ERR_BIT  = 1;
   localparam int STATUS_CNT_LSB  = 8;

endpackage

`default_nettype wire

/* hw/dma_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module dma_regs #(
   parameter int ADDR_W = 32,
   parameter int BUF_AW = 6
) (
   input  wire logic                        clk_i,
   input  wire logic                        rst_i,
   input  wire logic                        we_i,
   input  wire logic [dma_pkg::REG_AW-1:0]  addr_i,
   input  wire logic [31:0]                 wdata_i,
   output logic      [31:0]                 rdata_o,
   dma_cmd_if.regs                          cmd
);

   localparam int CNT_W = 32 - dma_pkg::STATUS_CNT_LSB;

   logic [ADDR_W-1:0]             axi_addr_q;
   logic [dma_pkg::AXI_LEN_W-1:0] len_q;
   logic [BUF_AW-1:0]             buf_start_q;
   logic                          start_q;
   logic [CNT_W-1:0]              done_cnt_q;
   logic                          ctrl_go;
   logic [31:0]                   status;

   // Start request, dropped while a transfer runs or a strobe is pending
   assign ctrl_go = we_i && (addr_i == dma_pkg::REG_CTRL) && wdata_i[0]
                    && !cmd.busy && !start_q;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         axi_addr_q  <= '0;
         len_q       <= '0;
         buf_start_q <= '0;
      end else if (we_i) begin
         case (addr_i)
            dma_pkg::REG_AXI_ADDR:  axi_addr_q  <= ADDR_W'(wdata_i);
            dma_pkg::REG_LEN:       len_q       <= wdata_i[dma_pkg::AXI_LEN_W-1:0];
            dma_pkg::REG_BUF_START: buf_start_q <= wdata_i[BUF_AW-1:0];
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         start_q <= 1'b0;
      end else begin
         start_q <= ctrl_go;
      end
   end

   // Completed transfers
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         done_cnt_q <= '0;
      end else if (cmd.done) begin
         done_cnt_q <= done_cnt_q + 1'b1;
      end
   end

   assign cmd.start     = start_q;
   assign cmd.axi_addr  = axi_addr_q;
   assign cmd.len       = len_q;
   assign cmd.buf_start = buf_start_q;

   always_comb begin
      status = '0;
      status[dma_pkg::STATUS_BUSY_BIT] = cmd.busy;
      status[dma_pkg::STATUS_ERR_BIT]  = cmd.error;
      status[31:dma_pkg::STATUS_CNT_LSB] = done_cnt_q;
   end

   // Combinational read mux
   always_comb begin
      case (addr_i)
         dma_pkg::REG_AXI_ADDR:  rdata_o = 32'(axi_addr_q);
         dma_pkg::REG_LEN:       rdata_o = 32'(len_q);
         dma_pkg::REG_BUF_START: rdata_o = 32'(buf_start_q);
         dma_pkg::REG_STATUS:    rdata_o = status;
         default:                rdata_o = 32'h0;
      endcase
   end

endmodule

`default_nettype wire

/* hw/dma_wr_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dma_wr_top #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32,
   parameter int BUF_AW = 6
) (
   input  wire logic                             clk_i,
   input  wire logic                             rst_i,

   // Host register port
   input  wire logic                             reg_we_i,
   input  wire logic [dma_pkg::REG_AW-1:0]       reg_addr_i,
   input  wire logic [31:0]                      reg_wdata_i,
   output logic      [31:0]                      reg_rdata_o,

   // Buffer fill port
   input  wire logic                             buf_we_i,
   input  wire logic [BUF_AW-1:0]                buf_addr_i,
   input  wire logic [DATA_W-1:0]                buf_wdata_i,

   output logic                                  done_o,

   // AXI4 write master
   output logic [ADDR_W-1:0]                     m_axi_awaddr_o,
   output logic [dma_pkg::AXI_LEN_W-1:0]         m_axi_awlen_o,
   output logic [dma_pkg::AXI_SIZE_W-1:0]        m_axi_awsize_o,
   output logic [dma_pkg::AXI_BURST_W-1:0]       m_axi_awburst_o,
   output logic                                  m_axi_awvalid_o,
   input  wire logic                             m_axi_awready_i,
   output logic [DATA_W-1:0]                     m_axi_wdata_o,
   output logic [DATA_W/8-1:0]                   m_axi_wstrb_o,
   output logic                                  m_axi_wlast_o,
   output logic                                  m_axi_wvalid_o,
   input  wire logic                             m_axi_wready_i,
   input  wire logic [dma_pkg::AXI_RESP_W-1:0]   m_axi_bresp_i,
   input  wire logic                             m_axi_bvalid_i,
   output logic                                  m_axi_bready_o
);

   dma_cmd_if #(.ADDR_W(ADDR_W), .BUF_AW(BUF_AW)) cmd_if ();
   buf_rd_if  #(.DATA_W(DATA_W), .BUF_AW(BUF_AW)) rd_if ();

   dma_regs #(
      .ADDR_W (ADDR_W),
      .BUF_AW (BUF_AW)
   ) u_regs (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .we_i    (reg_we_i),
      .addr_i  (reg_addr_i),
      .wdata_i (reg_wdata_i),
      .rdata_o (reg_rdata_o),
      .cmd     (cmd_if.regs)
   );

   wr_buffer #(
      .DATA_W (DATA_W),
      .BUF_AW (BUF_AW)
   ) u_buffer (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .we_i    (buf_we_i),
      .waddr_i (buf_addr_i),
      .wdata_i (buf_wdata_i),
      .rd      (rd_if.memory)
   );

   axi_burst_writer #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W),
      .BUF_AW (BUF_AW)
   ) u_writer (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .cmd             (cmd_if.engine),
      .rd              (rd_if.master),
      .m_axi_awaddr_o  (m_axi_awaddr_o),
      .m_axi_awlen_o   (m_axi_awlen_o),
      .m_axi_awsize_o  (m_axi_awsize_o),
      .m_axi_awburst_o (m_axi_awburst_o),
      .m_axi_awvalid_o (m_axi_awvalid_o),
      .m_axi_awready_i (m_axi_awready_i),
      .m_axi_wdata_o   (m_axi_wdata_o),
      .m_axi_wstrb_o   (m_axi_wstrb_o),
      .m_axi_wlast_o   (m_axi_wlast_o),
      .m_axi_wvalid_o  (m_axi_wvalid_o),
      .m_axi_wready_i  (m_axi_wready_i),
      .m_axi_bresp_i   (m_axi_bresp_i),
      .m_axi_bvalid_i  (m_axi_bvalid_i),
      .m_axi_bready_o  (m_axi_bready_o)
   );

   assign done_o = cmd_if.done;

endmodule

`default_nettype wire

/* hw/wr_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module wr_buffer #(
   parameter int DATA_W = 32,
   parameter int BUF_AW = 6
) (
   input  wire logic              clk_i,
   input  wire logic              rst_i,
   input  wire logic              we_i,
   input  wire logic [BUF_AW-1:0] waddr_i,
   input  wire logic [DATA_W-1:0] wdata_i,
   buf_rd_if.memory               rd
);

   localparam int DEPTH = 1 << BUF_AW;

   logic [DATA_W-1:0] mem [DEPTH];
   logic [DATA_W-1:0] rdata_q;
   logic              ready_q;

   // Host fill port
   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   // Registered read data
   always_ff @(posedge clk_i) begin
      if (rd.valid) begin
         rdata_q <= mem[rd.addr];
      end
   end

   // One-cycle ready after each request
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= rd.valid;
      end
   end

   assign rd.rdata = rdata_q;
   assign rd.ready = ready_q;

endmodule

`default_nettype wire
